// ==== verilog.f ====
+incdir+hw
hw/exec_pkg.sv
hw/operand_select_ex.sv
hw/mm_lane_ex.sv
hw/alu32_ex.sv
hw/result_select_ex.sv
hw/execute.sv
bench/execute_properties.sv
bench/execute_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module execute_tb \
  -f verilog.f -o execute_sim || exit 1
./obj_dir/execute_sim > sim.log 2>&1
cat sim.log
grep -q "ERRORS FOUND" sim.log && exit 1
grep -q "NO ERRORS" sim.log || exit 1
exit 0

// ==== bench/execute_tb.sv ====
`include "exec_config.svh"

module execute_tb;

  localparam int num_random = 300;
  localparam int wait_limit = 200;

  logic                 CLK;
  logic                 rst_n;
  logic                 ex_valid;
  exec_pkg::ex_uop_t    ex_uop;
  logic                 ex_ready;
  logic                 wb_valid;
  exec_pkg::wb_bundle_t wb;
  logic                 wb_ready;
  logic                 dep_ld_gpr1;
  logic                 dep_ld_gpr2;
  logic                 dep_ld_mm;

  exec_pkg::wb_bundle_t expected_q[$];
  logic [31:0]          rng_state;
  bit                   passed;
  bit                   fail_shown;

  execute dut_i (.*);

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // corner values show up often
  function automatic logic [31:0] pick_word();
    logic [31:0] r;
    r = next_rand();
    case (r[2:0])
      3'd0: return 32'h0000_0000;
      3'd1: return 32'hffff_ffff;
      3'd2: return 32'h7fff_ffff;
      3'd3: return 32'h8000_0000;
      default: return next_rand();
    endcase
  endfunction

  function automatic exec_pkg::wb_bundle_t ref_exec(input exec_pkg::ex_uop_t u);
    exec_pkg::wb_bundle_t r;
    exec_pkg::alu_op_e    op;
    logic [32:0]          wide;
    logic [31:0]          b_op;
    logic [16:0]          lane_sum;
    logic [15:0]          la;
    logic [15:0]          lb;
    int                   sh;
    r    = '0;
    op   = (u.kind == exec_pkg::kind_cmpxchg) ? exec_pkg::alu_sub : u.alu_op;
    b_op = (u.use_imm && u.kind != exec_pkg::kind_cmpxchg) ? u.imm : u.b;
    sh   = int'(b_op[4:0]);
    case (op)
      exec_pkg::alu_add: begin
        wide             = {1'b0, u.a} + {1'b0, b_op};
        r.result_a       = wide[31:0];
        r.flags.carry    = wide[32];
        r.flags.overflow = (u.a[31] == b_op[31]) && (wide[31] != u.a[31]);
      end
      exec_pkg::alu_sub: begin
        r.result_a       = u.a - b_op;
        r.flags.carry    = (u.a < b_op);
        r.flags.overflow = (u.a[31] != b_op[31]) && (r.result_a[31] != u.a[31]);
      end
      exec_pkg::alu_and: r.result_a = u.a & b_op;
      exec_pkg::alu_or:  r.result_a = u.a | b_op;
      exec_pkg::alu_xor: r.result_a = u.a ^ b_op;
      exec_pkg::alu_shl: begin
        r.result_a    = u.a << sh;
        r.flags.carry = (sh == 0) ? 1'b0 : u.a[32-sh];
      end
      default: r.result_a = u.a;
    endcase
    r.flags.zero = (r.result_a == 32'h0);
    r.flags.sign = r.result_a[31];
    for (int i = 0; i < `EXEC_NUM_LANES; i++) begin
      la       = u.mm_a[i*`EXEC_LANE_W +: `EXEC_LANE_W];
      lb       = u.mm_b[i*`EXEC_LANE_W +: `EXEC_LANE_W];
      lane_sum = {1'b0, la} + {1'b0, lb};
      case (u.mm_op)
        exec_pkg::mm_padd:   r.result_mm[i*16 +: 16] = lane_sum[15:0];
        exec_pkg::mm_paddus: r.result_mm[i*16 +: 16] = lane_sum[16] ? 16'hffff : lane_sum[15:0];
        exec_pkg::mm_psub:   r.result_mm[i*16 +: 16] = la - lb;
        default:             r.result_mm[i*16 +: 16] = la & lb;
      endcase
    end
    r.result_b = u.b;
    r.dr1      = u.dr1;
    r.dr2      = u.dr2;
    r.ld_gpr1  = u.ld_gpr1;
    r.ld_gpr2  = u.ld_gpr2;
    r.ld_mm    = u.ld_mm;
    if (u.kind == exec_pkg::kind_cmpxchg) begin
      r.result_a = u.c;
      r.ld_gpr1  = r.flags.zero;
      r.ld_gpr2  = !r.flags.zero;
    end else if (u.kind == exec_pkg::kind_mm) begin
      r.flags   = '0;
      r.ld_gpr1 = 1'b0;
      r.ld_gpr2 = 1'b0;
    end
    return r;
  endfunction

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
      fail_shown = 1'b1;
      $display("ERRORS FOUND");
      $fatal(1, "mismatch on %s", what);
    end
  endtask

  task automatic report_stall(input string what);
    $display("Timeout: no progress while waiting for %s", what);
    fail_shown = 1'b1;
    $display("ERRORS FOUND");
    $fatal(1, "simulation stalled");
  endtask

  task automatic compare_bundle(input exec_pkg::wb_bundle_t got,
                                input exec_pkg::wb_bundle_t exp);
    check_value("result_a", 64'(got.result_a), 64'(exp.result_a));
    check_value("result_b", 64'(got.result_b), 64'(exp.result_b));
    check_value("flags", 64'(got.flags), 64'(exp.flags));
    check_value("result_mm", got.result_mm, exp.result_mm);
    check_value("dr1", 64'(got.dr1), 64'(exp.dr1));
    check_value("dr2", 64'(got.dr2), 64'(exp.dr2));
    check_value("ld_gpr1", 64'(got.ld_gpr1), 64'(exp.ld_gpr1));
    check_value("ld_gpr2", 64'(got.ld_gpr2), 64'(exp.ld_gpr2));
    check_value("ld_mm", 64'(got.ld_mm), 64'(exp.ld_mm));
  endtask

  // scoreboard, sampled at the edge before any update
  always @(posedge CLK) begin
    exec_pkg::wb_bundle_t head;
    if (rst_n) begin
      head = (expected_q.size() != 0) ? expected_q[0] : '0;
      check_value("wb_valid", 64'(wb_valid), 64'(expected_q.size() != 0));
      check_value("ex_ready", 64'(ex_ready), 64'(expected_q.size() == 0 || wb_ready));
      check_value("dep_ld_gpr1", 64'(dep_ld_gpr1), 64'(head.ld_gpr1));
      check_value("dep_ld_gpr2", 64'(dep_ld_gpr2), 64'(head.ld_gpr2));
      check_value("dep_ld_mm", 64'(dep_ld_mm), 64'(head.ld_mm));
      if (wb_valid && wb_ready) begin
        compare_bundle(wb, expected_q[0]);
        void'(expected_q.pop_front());
      end
      if (ex_valid && ex_ready) begin
        expected_q.push_back(ref_exec(ex_uop));
      end
    end
  end

  task automatic step_clock();
    @(posedge CLK);
    // downstream takes about three cycles in four
    wb_ready <= (next_rand() % 4) != 0;
  endtask

  task automatic send_uop(input exec_pkg::ex_uop_t u);
    int gap;
    int waited;
    gap = int'(next_rand() % 3);
    if (gap != 0) begin
      ex_valid <= 1'b0;
      repeat (gap) step_clock();
    end
    ex_valid <= 1'b1;
    ex_uop   <= u;
    waited = 0;
    do begin
      step_clock();
      waited++;
      if (waited > wait_limit) report_stall("ex_ready");
    end while (!(ex_valid && ex_ready));
  endtask

  function automatic exec_pkg::ex_uop_t alu_uop(input exec_pkg::alu_op_e op,
      input logic [31:0] a, input logic [31:0] b, input logic use_imm);
    exec_pkg::ex_uop_t u;
    u         = '0;
    u.kind    = exec_pkg::kind_alu;
    u.alu_op  = op;
    u.a       = a;
    // the unused source holds the inverse so a wrong pick shows
    u.b       = use_imm ? ~b : b;
    u.imm     = use_imm ? b : ~b;
    u.use_imm = use_imm;
    u.dr1     = 3'd1;
    u.dr2     = 3'd2;
    u.ld_gpr1 = 1'b1;
    return u;
  endfunction

  function automatic exec_pkg::ex_uop_t cmpxchg_uop(input logic [31:0] a, input logic [31:0] b);
    exec_pkg::ex_uop_t u;
    u         = alu_uop(exec_pkg::alu_add, a, b, 1'b0);
    u.kind    = exec_pkg::kind_cmpxchg;
    u.c       = 32'hc0de_0042;
    u.imm     = 32'h0000_0001;
    u.use_imm = 1'b1;
    u.dr2     = 3'd5;
    return u;
  endfunction

  function automatic exec_pkg::ex_uop_t mm_uop(input exec_pkg::mm_op_e op,
      input logic [63:0] a, input logic [63:0] b);
    exec_pkg::ex_uop_t u;
    u       = alu_uop(exec_pkg::alu_add, 32'h1, 32'h2, 1'b0);
    u.kind  = exec_pkg::kind_mm;
    u.mm_op = op;
    u.mm_a  = a;
    u.mm_b  = b;
    u.ld_mm = 1'b1;
    return u;
  endfunction

  function automatic exec_pkg::ex_uop_t random_uop();
    exec_pkg::ex_uop_t u;
    logic [31:0]       r;
    u         = '0;
    r         = next_rand();
    u.kind    = exec_pkg::uop_kind_e'(2'(r % 3));
    u.alu_op  = exec_pkg::alu_op_e'(3'((r >> 4) % 7));
    u.mm_op   = exec_pkg::mm_op_e'(r[9:8]);
    u.use_imm = r[10];
    u.dr1     = r[13:11];
    u.dr2     = r[16:14];
    u.ld_gpr1 = r[17];
    u.ld_gpr2 = r[18];
    u.ld_mm   = r[19];
    u.a       = pick_word();
    // equal operands now and then for cmpxchg
    u.b       = r[21:20] == 2'b00 ? u.a : pick_word();
    u.c       = pick_word();
    u.imm     = pick_word();
    u.mm_a    = {pick_word(), pick_word()};
    u.mm_b    = {pick_word(), pick_word()};
    return u;
  endfunction

  initial begin
    int waited;
    rng_state = 32'd20317;
    rst_n     = 1'b0;
    ex_valid  = 1'b0;
    ex_uop    = '0;
    wb_ready  = 1'b0;
    repeat (10) step_clock();
    rst_n <= 1'b1;
    repeat (3) step_clock();

    send_uop(alu_uop(exec_pkg::alu_add, 32'hffff_ffff, 32'h1, 1'b0));
    send_uop(alu_uop(exec_pkg::alu_add, 32'h7fff_ffff, 32'h1, 1'b1));
    send_uop(alu_uop(exec_pkg::alu_sub, 32'h0, 32'h1, 1'b0));
    send_uop(alu_uop(exec_pkg::alu_sub, 32'h8000_0000, 32'h1, 1'b1));
    send_uop(alu_uop(exec_pkg::alu_and, 32'hf0f0_1234, 32'h0ff0_ffff, 1'b0));
    send_uop(alu_uop(exec_pkg::alu_or, 32'h8000_0000, 32'h0000_0001, 1'b1));
    send_uop(alu_uop(exec_pkg::alu_xor, 32'h5a5a_5a5a, 32'h5a5a_5a5a, 1'b0));
    send_uop(alu_uop(exec_pkg::alu_shl, 32'h8000_0001, 32'h0, 1'b0));
    send_uop(alu_uop(exec_pkg::alu_shl, 32'h8000_0003, 32'd31, 1'b1));
    send_uop(alu_uop(exec_pkg::alu_shl, 32'h4000_0001, 32'd2, 1'b0));
    send_uop(alu_uop(exec_pkg::alu_pass_a, 32'h0, 32'h1234, 1'b0));
    send_uop(cmpxchg_uop(32'h1234_5678, 32'h1234_5678));
    send_uop(cmpxchg_uop(32'h1234_5678, 32'h1234_5679));
    send_uop(mm_uop(exec_pkg::mm_padd, 64'hffff_0001_8000_1234, 64'h0001_ffff_8000_4321));
    send_uop(mm_uop(exec_pkg::mm_paddus, 64'hffff_0001_8000_1234, 64'h0001_fffe_8000_4321));
    send_uop(mm_uop(exec_pkg::mm_psub, 64'h0000_0005_8000_ffff, 64'h0001_0005_0001_fffe));
    send_uop(mm_uop(exec_pkg::mm_pand, 64'hff00_0ff0_ffff_0000, 64'h0f0f_ffff_1234_ffff));

    repeat (num_random) send_uop(random_uop());

    ex_valid <= 1'b0;
    waited = 0;
    do begin
      step_clock();
      waited++;
      if (waited > wait_limit) report_stall("the output register to drain");
    end while (wb_valid);

    if (!fail_shown) begin
      passed = 1'b1;
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // runs that stop early, such as on a failed assertion
  final begin
    if (!passed && !fail_shown) begin
      $display("ERRORS FOUND");
    end
  end

endmodule

// ==== bench/execute_properties.sv ====
module execute_properties (
  input logic                 CLK,
  input logic                 rst_n,
  input logic                 wb_valid,
  input logic                 wb_ready,
  input exec_pkg::wb_bundle_t wb,
  input logic                 dep_ld_gpr1,
  input logic                 dep_ld_gpr2,
  input logic                 dep_ld_mm
);

  // held bundle stays put under back-pressure
  wb_hold_a: assert property (
    @(posedge CLK) disable iff (!rst_n)
    (wb_valid && !wb_ready) |=> (wb_valid && $stable(wb))
  ) else $error("wb changed while the output was stalled");

  dep_idle_a: assert property (
    @(posedge CLK) !wb_valid |-> !(dep_ld_gpr1 || dep_ld_gpr2 || dep_ld_mm)
  ) else $error("dependency output high with no bundle held");

  reset_idle_a: assert property (
    @(posedge CLK) !rst_n |-> !wb_valid
  ) else $error("wb_valid high during reset");

endmodule

bind execute execute_properties props_i (
  .CLK         (CLK),
  .rst_n       (rst_n),
  .wb_valid    (wb_valid),
  .wb_ready    (wb_ready),
  .wb          (wb),
  .dep_ld_gpr1 (dep_ld_gpr1),
  .dep_ld_gpr2 (dep_ld_gpr2),
  .dep_ld_mm   (dep_ld_mm)
);

// ==== hw/execute.sv ====
`include "exec_config.svh"

module execute (
  input  logic                 CLK,
  input  logic                 rst_n,

  // upstream side
  input  logic                 ex_valid,
  input  exec_pkg::ex_uop_t    ex_uop,
  output logic                 ex_ready,

  // downstream side
  output logic                 wb_valid,
  output exec_pkg::wb_bundle_t wb,
  input  logic                 wb_ready,

  // to hazard logic
  output logic                 dep_ld_gpr1,
  output logic                 dep_ld_gpr2,
  output logic                 dep_ld_mm
);

  exec_pkg::word_t      b_sel;
  exec_pkg::shamt_t     shamt;
  exec_pkg::alu_op_e    alu_op;
  exec_pkg::word_t      alu_result;
  exec_pkg::flags_t     alu_flags;
  exec_pkg::lane_req_t  lane_reqs [`EXEC_NUM_LANES];
  exec_pkg::lane_t      lane_res [`EXEC_NUM_LANES];
  exec_pkg::wb_bundle_t wb_next;
  logic                 accept;

  operand_select_ex u_operand_select_ex (
    .uop       (ex_uop),
    .b_sel     (b_sel),
    .shamt     (shamt),
    .lane_reqs (lane_reqs)
  );

  // cmpxchg compares by subtracting
  assign alu_op = (ex_uop.kind == exec_pkg::kind_cmpxchg) ? exec_pkg::alu_sub : ex_uop.alu_op;

  alu32_ex u_alu32_ex (
    .op     (alu_op),
    .a      (ex_uop.a),
    .b      (b_sel),
    .shamt  (shamt),
    .result (alu_result),
    .flags  (alu_flags)
  );

  for (genvar i = 0; i < `EXEC_NUM_LANES; i++) begin : g_lane
    mm_lane_ex u_mm_lane_ex (
      .req (lane_reqs[i]),
      .res (lane_res[i])
    );
  end

  result_select_ex u_result_select_ex (
    .uop        (ex_uop),
    .alu_result (alu_result),
    .alu_flags  (alu_flags),
    .lane_res   (lane_res),
    .wb_next    (wb_next)
  );

  // single output register, refills in the cycle it drains
  assign ex_ready = ~wb_valid | wb_ready;
  assign accept   = ex_valid & ex_ready;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid <= 1'b0;
    end else if (ex_ready) begin
      wb_valid <= ex_valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (accept) begin
      wb <= wb_next;
    end
  end

  // pending writes of the bundle on offer
  assign dep_ld_gpr1 = wb_valid & wb.ld_gpr1;
  assign dep_ld_gpr2 = wb_valid & wb.ld_gpr2;
  assign dep_ld_mm   = wb_valid & wb.ld_mm;

endmodule

// ==== hw/result_select_ex.sv ====
`include "exec_config.svh"

module result_select_ex (
  input  exec_pkg::ex_uop_t    uop,
  input  exec_pkg::word_t      alu_result,
  input  exec_pkg::flags_t     alu_flags,
  input  exec_pkg::lane_t      lane_res [`EXEC_NUM_LANES],
  output exec_pkg::wb_bundle_t wb_next
);

  exec_pkg::mm_t result_mm;

  // gather lanes back into the packed register
  always_comb begin
    result_mm = '0;
    for (int i = 0; i < `EXEC_NUM_LANES; i++) begin
      result_mm[i*`EXEC_LANE_W +: `EXEC_LANE_W] = lane_res[i];
    end
  end

  always_comb begin
    // plain alu defaults
    wb_next.result_a  = alu_result;
    wb_next.result_b  = uop.b;
    wb_next.flags     = alu_flags;
    wb_next.result_mm = result_mm;
    wb_next.dr1       = uop.dr1;
    wb_next.dr2       = uop.dr2;
    wb_next.ld_gpr1   = uop.ld_gpr1;
    wb_next.ld_gpr2   = uop.ld_gpr2;
    wb_next.ld_mm     = uop.ld_mm;
    if (uop.kind == exec_pkg::kind_cmpxchg) begin
      // c goes to dr1 on equal operands and b to dr2 otherwise
      wb_next.result_a = uop.c;
      wb_next.ld_gpr1  = alu_flags.zero;
      wb_next.ld_gpr2  = ~alu_flags.zero;
    end else if (uop.kind == exec_pkg::kind_mm) begin
      wb_next.flags   = '0;
      wb_next.ld_gpr1 = 1'b0;
      wb_next.ld_gpr2 = 1'b0;
    end
  end

endmodule

// ==== hw/alu32_ex.sv ====
`include "exec_config.svh"

module alu32_ex (
  input  exec_pkg::alu_op_e op,
  input  exec_pkg::word_t   a,
  input  exec_pkg::word_t   b,
  input  exec_pkg::shamt_t  shamt,
  output exec_pkg::word_t   result,
  output exec_pkg::flags_t  flags
);

  logic                  is_sub;
  exec_pkg::word_t       b_add;
  exec_pkg::word_t       sum;
  logic                  carry_out;
  logic                  add_ovf;
  logic [`EXEC_WORD_W:0] shl_wide;

  // single adder, sub is a + ~b + 1
  assign is_sub = (op == exec_pkg::alu_sub);
  assign b_add  = is_sub ? ~b : b;
  assign {carry_out, sum} = {1'b0, a} + {1'b0, b_add} + is_sub;

  // signed overflow seen on the operands actually added
  assign add_ovf = (a[`EXEC_WORD_W-1] == b_add[`EXEC_WORD_W-1]) &&
                   (sum[`EXEC_WORD_W-1] != a[`EXEC_WORD_W-1]);

  // top bit holds the last bit shifted out, zero for a zero count
  assign shl_wide = {1'b0, a} << shamt;

  always_comb begin
    result         = a;
    flags.carry    = 1'b0;
    flags.overflow = 1'b0;
    case (op)
      exec_pkg::alu_add: begin
        result         = sum;
        flags.carry    = carry_out;
        flags.overflow = add_ovf;
      end
      exec_pkg::alu_sub: begin
        result         = sum;
        // borrow is the inverted carry
        flags.carry    = ~carry_out;
        flags.overflow = add_ovf;
      end
      exec_pkg::alu_and: result = a & b;
      exec_pkg::alu_or:  result = a | b;
      exec_pkg::alu_xor: result = a ^ b;
      exec_pkg::alu_shl: begin
        result      = shl_wide[`EXEC_WORD_W-1:0];
        flags.carry = shl_wide[`EXEC_WORD_W];
      end
      default: result = a;
    endcase
    flags.zero = (result == '0);
    flags.sign = result[`EXEC_WORD_W-1];
  end

endmodule

// ==== hw/mm_lane_ex.sv ====
`include "exec_config.svh"

module mm_lane_ex (
  input  exec_pkg::lane_req_t req,
  output exec_pkg::lane_t     res
);

  // one extra bit to see the unsigned carry
  logic [`EXEC_LANE_W:0] add_wide;

  assign add_wide = {1'b0, req.a} + {1'b0, req.b};

  always_comb begin
    case (req.op)
      exec_pkg::mm_padd: begin
        res = add_wide[`EXEC_LANE_W-1:0];
      end
      exec_pkg::mm_paddus: begin
        // clamp to all ones on carry out
        res = add_wide[`EXEC_LANE_W] ? '1 : add_wide[`EXEC_LANE_W-1:0];
      end
      exec_pkg::mm_psub: begin
        res = req.a - req.b;
      end
      default: begin
        res = req.a & req.b;
      end
    endcase
  end

endmodule

// ==== hw/operand_select_ex.sv ====
`include "exec_config.svh"

module operand_select_ex (
  input  exec_pkg::ex_uop_t   uop,
  output exec_pkg::word_t     b_sel,
  output exec_pkg::shamt_t    shamt,
  output exec_pkg::lane_req_t lane_reqs [`EXEC_NUM_LANES]
);

  logic imm_ok;

  // cmpxchg always compares against the register operand
  assign imm_ok = uop.use_imm && (uop.kind != exec_pkg::kind_cmpxchg);

  assign b_sel = imm_ok ? uop.imm : uop.b;

  // count comes from the low bits of b
  assign shamt = b_sel[$bits(exec_pkg::shamt_t)-1:0];

  // slice packed operands, lane 0 at the low end
  always_comb begin
    for (int i = 0; i < `EXEC_NUM_LANES; i++) begin
      lane_reqs[i].op = uop.mm_op;
      lane_reqs[i].a  = uop.mm_a[i*`EXEC_LANE_W +: `EXEC_LANE_W];
      lane_reqs[i].b  = uop.mm_b[i*`EXEC_LANE_W +: `EXEC_LANE_W];
    end
  end

endmodule

// ==== hw/exec_pkg.sv ====
`include "exec_config.svh"

package exec_pkg;

  typedef logic [`EXEC_WORD_W-1:0]         word_t;
  typedef logic [`EXEC_MM_W-1:0]           mm_t;
  typedef logic [`EXEC_LANE_W-1:0]         lane_t;
  typedef logic [`EXEC_REG_IDX_W-1:0]      reg_idx_t;
  typedef logic [$clog2(`EXEC_WORD_W)-1:0] shamt_t;

  // operation kinds, the stage has no FSM
  typedef enum logic [1:0] {
    kind_alu,
    kind_cmpxchg,
    kind_mm
  } uop_kind_e;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_shl,
    alu_pass_a
  } alu_op_e;

  // paddus saturates unsigned
  typedef enum logic [1:0] {
    mm_padd,
    mm_paddus,
    mm_psub,
    mm_pand
  } mm_op_e;

  typedef struct packed {
    logic zero;
    logic sign;
    logic carry;
    logic overflow;
  } flags_t;

  typedef struct packed {
    uop_kind_e kind;
    alu_op_e   alu_op;
    mm_op_e    mm_op;
    word_t     a;
    word_t     b;
    word_t     c;
    word_t     imm;
    logic      use_imm;
    mm_t       mm_a;
    mm_t       mm_b;
    reg_idx_t  dr1;
    reg_idx_t  dr2;
    logic      ld_gpr1;
    logic      ld_gpr2;
    logic      ld_mm;
  } ex_uop_t;

  typedef struct packed {
    mm_op_e op;
    lane_t  a;
    lane_t  b;
  } lane_req_t;

  typedef struct packed {
    word_t    result_a;
    word_t    result_b;
    flags_t   flags;
    mm_t      result_mm;
    reg_idx_t dr1;
    reg_idx_t dr2;
    logic     ld_gpr1;
    logic     ld_gpr2;
    logic     ld_mm;
  } wb_bundle_t;

endpackage

// ==== hw/exec_config.svh ====
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// general register width
`define EXEC_WORD_W 32

// packed multimedia register width
`define EXEC_MM_W 64

// one packed lane
`define EXEC_LANE_W 16

`define EXEC_NUM_LANES (`EXEC_MM_W / `EXEC_LANE_W)

// eight architectural registers per file
`define EXEC_REG_IDX_W 3

`endif
